// ==== logic/fifo_ecc_defines.svh ====
`ifndef FIFO_ECC_DEFINES_SVH
`define FIFO_ECC_DEFINES_SVH

// Word geometry
`define FIFO_DATA_W     64
`define FIFO_CHECK_W    8

// Storage geometry
`define FIFO_ADDR_W     9
`define FIFO_DEPTH      512

// Data bits flipped by the injection inputs
`define ECC_INJ_BIT_LO  30
`define ECC_INJ_BIT_HI  62

`endif

// ==== logic/fifo_ecc_pkg.sv ====
`include "fifo_ecc_defines.svh"

package fifo_ecc_pkg;

    typedef logic [`FIFO_DATA_W-1:0]  data_t;   // One data word
    typedef logic [`FIFO_CHECK_W-1:0] check_t;  // [7] overall parity, [6:0] Hamming
    typedef logic [`FIFO_ADDR_W-1:0]  addr_t;   // Memory index
    typedef logic [`FIFO_ADDR_W:0]    ptr_t;    // Index plus wrap bit

    // ==================================================
    // Hamming column masks, one per check bit
    // ==================================================

    //                       [6]     [5]                             [4]             [3]     [2] [1..0]
    localparam data_t HAMMING_MASK [0:6] = '{
        64'b1010101_1010101010101010101010101010101_101010101010101_1010101_101_1,
        64'b1100110_1100110011001100110011001100110_110011001100110_1100110_110_1,
        64'b1111000_1111000011110000111100001111000_111100001111000_1111000_111_0,
        64'b0000000_1111111100000000111111110000000_111111110000000_1111111_000_0,
        64'b0000000_1111111111111111000000000000000_111111111111111_0000000_000_0,
        64'b0000000_1111111111111111111111111111111_000000000000000_0000000_000_0,
        64'b1111111_0000000000000000000000000000000_000000000000000_0000000_000_0
    };

    // Seven Hamming bits of a data word
    function automatic logic [6:0] hamming_of(input data_t d);
        logic [6:0] h;
        for (int i = 0; i < 7; i++) begin
            h[i] = ^(d & HAMMING_MASK[i]);
        end
        return h;
    endfunction

endpackage

// ==== logic/ecc_encoder.sv ====
`timescale 1ns/1ps

`include "fifo_ecc_defines.svh"

module ecc_encoder
    import fifo_ecc_pkg::*;
(
    input  data_t  wr_data_i,
    input  logic   inj_sbit_i,
    input  logic   inj_dbit_i,
    output data_t  enc_data_o,
    output check_t enc_check_o
);

    // ==================================================
    // Check bits over the clean word
    // ==================================================

    logic [6:0] hamming;
    logic       overall;

    assign hamming = hamming_of(wr_data_i);
    assign overall = ^{hamming, wr_data_i};  // Parity over all 71 other bits

    assign enc_check_o = {overall, hamming};

    // ==================================================
    // Error injection
    // ==================================================

    data_t inj_mask;

    always_comb begin
        inj_mask = '0;
        if (inj_dbit_i) begin                // Double wins over single
            inj_mask[`ECC_INJ_BIT_LO] = 1'b1;
            inj_mask[`ECC_INJ_BIT_HI] = 1'b1;
        end else if (inj_sbit_i) begin
            inj_mask[`ECC_INJ_BIT_LO] = 1'b1;
        end
    end

    // Flip after encoding so the stored check bits disagree with the data
    assign enc_data_o = wr_data_i ^ inj_mask;

endmodule

// ==== logic/fifo_store.sv ====
`timescale 1ns/1ps

`include "fifo_ecc_defines.svh"

module fifo_store
    import fifo_ecc_pkg::*;
(
    input  logic   _w_RDCLK,
    input  logic   _w_GSR,
    input  logic   wr_en_i,
    input  data_t  wr_data_i,
    input  check_t wr_check_i,
    input  logic   rd_en_i,
    output data_t  rd_data_o,
    output check_t rd_check_o,
    output logic   rd_fire_o,
    output logic   full_o,
    output logic   empty_o,
    output logic   wr_err_o,
    output logic   rd_err_o
);

    // ==================================================
    // Storage arrays
    // ==================================================

    data_t  mem_data  [`FIFO_DEPTH];
    check_t mem_check [`FIFO_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    addr_t wr_addr;
    addr_t rd_addr;

    logic wr_fire;

    assign wr_addr = wr_ptr[`FIFO_ADDR_W-1:0];
    assign rd_addr = rd_ptr[`FIFO_ADDR_W-1:0];

    // ==================================================
    // Flags and accept conditions
    // ==================================================

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_addr == rd_addr) &&
                     (wr_ptr[`FIFO_ADDR_W] != rd_ptr[`FIFO_ADDR_W]);  // Same slot, one lap apart

    assign wr_fire   = wr_en_i & ~full_o;
    assign rd_fire_o = rd_en_i & ~empty_o;

    // Write port
    always_ff @(posedge _w_RDCLK) begin
        if (wr_fire) begin
            mem_data[wr_addr]  <= wr_data_i;
            mem_check[wr_addr] <= wr_check_i;
        end
    end

    // Head of the queue, sampled by the decoder on rd_fire_o
    assign rd_data_o  = mem_data[rd_addr];
    assign rd_check_o = mem_check[rd_addr];

    // ==================================================
    // Pointers and rejection pulses
    // ==================================================

    always_ff @(posedge _w_RDCLK or posedge _w_GSR) begin
        if (_w_GSR) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr_err_o <= 1'b0;
            rd_err_o <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire_o) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            wr_err_o <= wr_en_i & full_o;   // Dropped write
            rd_err_o <= rd_en_i & empty_o;  // Dropped read
        end
    end

endmodule

// ==== logic/ecc_decoder.sv ====
`timescale 1ns/1ps

`include "fifo_ecc_defines.svh"

module ecc_decoder
    import fifo_ecc_pkg::*;
(
    input  logic   _w_RDCLK,
    input  logic   _w_GSR,
    input  logic   rd_fire_i,
    input  data_t  raw_data_i,
    input  check_t raw_check_i,
    output data_t  rd_data_o,
    output logic   sbit_err_o,
    output logic   dbit_err_o
);

    localparam int CW_W = `FIFO_DATA_W + `FIFO_CHECK_W;

    // ==================================================
    // Syndrome and classification
    // ==================================================

    check_t syndrome;
    logic   sbit;
    logic   dbit;

    assign syndrome[6:0] = raw_check_i[6:0] ^ hamming_of(raw_data_i);
    assign syndrome[7]   = ^{raw_check_i, raw_data_i};  // Zero for an even number of flips

    assign sbit = (|syndrome) &  syndrome[7];
    assign dbit = (|syndrome) & ~syndrome[7];

    // ==================================================
    // Single-bit correction
    // ==================================================

    logic [CW_W-1:0] codeword;
    data_t           fixed_data;

    always_comb begin
        // Check bits sit at the power-of-two positions, overall parity at 0
        codeword = {raw_data_i[63:57], raw_check_i[6], raw_data_i[56:26], raw_check_i[5],
                    raw_data_i[25:11], raw_check_i[4], raw_data_i[10:4], raw_check_i[3],
                    raw_data_i[3:1], raw_check_i[2], raw_data_i[0], raw_check_i[1:0],
                    raw_check_i[7]};
        if (sbit && (int'(syndrome[6:0]) < CW_W)) begin
            codeword[syndrome[6:0]] = ~codeword[syndrome[6:0]];
        end
        fixed_data = {codeword[71:65], codeword[63:33], codeword[31:17],
                      codeword[15:9], codeword[7:5], codeword[3]};
    end

    // Output register, updated only by an accepted read
    always_ff @(posedge _w_RDCLK or posedge _w_GSR) begin
        if (_w_GSR) begin
            rd_data_o  <= '0;
            sbit_err_o <= 1'b0;
            dbit_err_o <= 1'b0;
        end else if (rd_fire_i) begin
            rd_data_o  <= fixed_data;  // Equals raw data unless sbit
            sbit_err_o <= sbit;
            dbit_err_o <= dbit;
        end
    end

endmodule

// ==== logic/fifo_ecc_top.sv ====
`timescale 1ns/1ps

module fifo_ecc_top
    import fifo_ecc_pkg::*;
(
    input  logic  _w_RDCLK,
    input  logic  _w_GSR,
    input  logic  wr_en_i,
    input  data_t wr_data_i,
    input  logic  inj_sbit_i,
    input  logic  inj_dbit_i,
    input  logic  rd_en_i,
    output data_t rd_data_o,
    output logic  sbit_err_o,
    output logic  dbit_err_o,
    output logic  full_o,
    output logic  empty_o,
    output logic  wr_err_o,
    output logic  rd_err_o
);

    data_t  enc_data;   // Possibly injected word
    check_t enc_check;  // Check bits of the clean word
    data_t  raw_data;
    check_t raw_check;
    logic   rd_fire;

    ecc_encoder fifo_ecc_encoder (
        .wr_data_i   (wr_data_i),
        .inj_sbit_i  (inj_sbit_i),
        .inj_dbit_i  (inj_dbit_i),
        .enc_data_o  (enc_data),
        .enc_check_o (enc_check)
    );

    fifo_store fifo_ecc_store (
        ._w_RDCLK   (_w_RDCLK),
        ._w_GSR     (_w_GSR),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (enc_data),
        .wr_check_i (enc_check),
        .rd_en_i    (rd_en_i),
        .rd_data_o  (raw_data),
        .rd_check_o (raw_check),
        .rd_fire_o  (rd_fire),
        .full_o     (full_o),
        .empty_o    (empty_o),
        .wr_err_o   (wr_err_o),
        .rd_err_o   (rd_err_o)
    );

    ecc_decoder fifo_ecc_decoder (
        ._w_RDCLK    (_w_RDCLK),
        ._w_GSR      (_w_GSR),
        .rd_fire_i   (rd_fire),
        .raw_data_i  (raw_data),
        .raw_check_i (raw_check),
        .rd_data_o   (rd_data_o),
        .sbit_err_o  (sbit_err_o),
        .dbit_err_o  (dbit_err_o)
    );

endmodule

// ==== verification/fifo_ecc_sva.sv ====
`timescale 1ns/1ps

module fifo_ecc_sva
    import fifo_ecc_pkg::*;
(
    input logic _w_RDCLK,
    input logic _w_GSR,
    input logic wr_en_i,
    input logic rd_en_i,
    input logic full_o,
    input logic empty_o,
    input logic wr_err_o,
    input logic rd_err_o,
    input logic sbit_err_o,
    input logic dbit_err_o
);

    int unsigned fail_count = 0;  // Polled by the testbench

    // ==================================================
    // Flag and error protocol
    // ==================================================

    a_full_empty_excl : assert property (@(posedge _w_RDCLK) disable iff (_w_GSR)
        !(full_o && empty_o))
        else begin
            $error("full_o and empty_o high together");
            fail_count++;
        end

    // Each pulse follows exactly one dropped request
    a_wr_err_pulse : assert property (@(posedge _w_RDCLK) disable iff (_w_GSR)
        wr_err_o == $past(wr_en_i && full_o))
        else begin
            $error("wr_err_o does not match a dropped write");
            fail_count++;
        end

    a_rd_err_pulse : assert property (@(posedge _w_RDCLK) disable iff (_w_GSR)
        rd_err_o == $past(rd_en_i && empty_o))
        else begin
            $error("rd_err_o does not match a dropped read");
            fail_count++;
        end

    a_ecc_flags_excl : assert property (@(posedge _w_RDCLK) disable iff (_w_GSR)
        !(sbit_err_o && dbit_err_o))
        else begin
            $error("sbit_err_o and dbit_err_o high together");
            fail_count++;
        end

endmodule

bind fifo_ecc_top fifo_ecc_sva fifo_ecc_sva_i (
    ._w_RDCLK   (_w_RDCLK),
    ._w_GSR     (_w_GSR),
    .wr_en_i    (wr_en_i),
    .rd_en_i    (rd_en_i),
    .full_o     (full_o),
    .empty_o    (empty_o),
    .wr_err_o   (wr_err_o),
    .rd_err_o   (rd_err_o),
    .sbit_err_o (sbit_err_o),
    .dbit_err_o (dbit_err_o)
);

// ==== verification/fifo_ecc_tb.sv ====
`timescale 1ns/1ps

`include "fifo_ecc_defines.svh"

module fifo_ecc_tb
    import fifo_ecc_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;  // Tests need roughly 1100 cycles

    logic  _w_RDCLK;
    logic  _w_GSR;
    logic  wr_en;
    data_t wr_data;
    logic  inj_sbit;
    logic  inj_dbit;
    logic  rd_en;
    data_t rd_data;
    logic  sbit_err;
    logic  dbit_err;
    logic  full;
    logic  empty;
    logic  wr_err;
    logic  rd_err;

    string       test_name = "none";
    int unsigned cycle_count = 0;
    logic [31:0] lfsr_state = 32'h1d9c;
    data_t       expected_q [$];
    data_t       last_read = '0;  // Word most recently drained in order

    fifo_ecc_top fifo_ecc_top_i (
        ._w_RDCLK   (_w_RDCLK),
        ._w_GSR     (_w_GSR),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .inj_sbit_i (inj_sbit),
        .inj_dbit_i (inj_dbit),
        .rd_en_i    (rd_en),
        .rd_data_o  (rd_data),
        .sbit_err_o (sbit_err),
        .dbit_err_o (dbit_err),
        .full_o     (full),
        .empty_o    (empty),
        .wr_err_o   (wr_err),
        .rd_err_o   (rd_err)
    );

    initial begin
        _w_RDCLK = 1'b0;
        forever #4 _w_RDCLK = ~_w_RDCLK;
    end

    // Ends the run on a stuck test or a failed bound assertion
    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES &&
               fifo_ecc_top_i.fifo_ecc_sva_i.fail_count == 0) begin
            @(posedge _w_RDCLK);
            cycle_count++;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
        end else begin
            $display("A bound assertion failed during test %s", test_name);
        end
        $display("Result: FAILED");
        $fatal(1, "Run aborted");
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic data_t random_word();
        data_t w;
        for (int i = 0; i < `FIFO_DATA_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
        return w;
    endfunction

    task automatic next_cycle();
        @(posedge _w_RDCLK);
        #1;
    endtask

    task automatic push_word(input data_t d, input logic sbit, input logic dbit);
        while (full) begin
            next_cycle();
        end
        wr_en    = 1'b1;
        wr_data  = d;
        inj_sbit = sbit;
        inj_dbit = dbit;
        next_cycle();
        wr_en    = 1'b0;
        inj_sbit = 1'b0;
        inj_dbit = 1'b0;
    endtask

    task automatic pop_word();
        while (empty) begin
            next_cycle();
        end
        rd_en = 1'b1;
        next_cycle();  // Result registered at this edge
        rd_en = 1'b0;
    endtask

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================

    task automatic reset_state();
        test_name = "reset_state";
        check_flag("empty_o", 1'b1, empty);
        check_flag("full_o", 1'b0, full);
        check_flag("wr_err_o", 1'b0, wr_err);
        check_flag("rd_err_o", 1'b0, rd_err);
        check_flag("sbit_err_o", 1'b0, sbit_err);
        check_flag("dbit_err_o", 1'b0, dbit_err);
        check_data("rd_data_o", '0, rd_data);
    endtask

    task automatic drain_and_check(input int count);
        data_t exp;
        for (int i = 0; i < count; i++) begin
            exp = expected_q.pop_front();
            pop_word();
            check_data("rd_data_o", exp, rd_data);
            check_flag("sbit_err_o", 1'b0, sbit_err);
            check_flag("dbit_err_o", 1'b0, dbit_err);
            last_read = exp;
        end
        check_flag("empty_o", 1'b1, empty);
    endtask

    task automatic clean_round_trip();
        data_t w;
        test_name = "clean_round_trip";
        for (int i = 0; i < 20; i++) begin
            w = random_word();
            expected_q.push_back(w);
            push_word(w, 1'b0, 1'b0);
        end
        drain_and_check(20);
    endtask

    task automatic single_bit_inject();
        data_t w;
        test_name = "single_inject";
        w = random_word();
        push_word(w, 1'b1, 1'b0);
        pop_word();
        check_data("rd_data_o", w, rd_data);  // Corrected on read
        check_flag("sbit_err_o", 1'b1, sbit_err);
        check_flag("dbit_err_o", 1'b0, dbit_err);
    endtask

    task automatic double_bit_inject();
        data_t w;
        data_t flips;
        test_name = "double_inject";
        w = random_word();
        flips = '0;
        flips[`ECC_INJ_BIT_LO] = 1'b1;
        flips[`ECC_INJ_BIT_HI] = 1'b1;
        push_word(w, 1'b1, 1'b1);  // Double takes priority
        pop_word();
        check_data("rd_data_o", w ^ flips, rd_data);
        check_flag("sbit_err_o", 1'b0, sbit_err);
        check_flag("dbit_err_o", 1'b1, dbit_err);
    endtask

    task automatic fill_and_overflow();
        data_t w;
        test_name = "fill_overflow";
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            w = random_word();
            expected_q.push_back(w);
            push_word(w, 1'b0, 1'b0);
        end
        check_flag("full_o", 1'b1, full);
        check_flag("empty_o", 1'b0, empty);
        wr_en   = 1'b1;  // Dropped write
        wr_data = random_word();
        next_cycle();
        wr_en = 1'b0;
        check_flag("wr_err_o", 1'b1, wr_err);
        next_cycle();
        check_flag("wr_err_o", 1'b0, wr_err);
        drain_and_check(`FIFO_DEPTH);
    endtask

    // Output must still show the last word drained before
    task automatic read_underflow();
        test_name = "underflow";
        rd_en = 1'b1;
        next_cycle();
        rd_en = 1'b0;
        check_flag("rd_err_o", 1'b1, rd_err);
        check_data("rd_data_o", last_read, rd_data);
        next_cycle();
        check_flag("rd_err_o", 1'b0, rd_err);
        check_data("rd_data_o", last_read, rd_data);
    endtask

    // ==================================================
    // Sequence and verdict
    // ==================================================

    initial begin : main
        _w_GSR   = 1'b1;
        wr_en    = 1'b0;
        wr_data  = '0;
        inj_sbit = 1'b0;
        inj_dbit = 1'b0;
        rd_en    = 1'b0;
        repeat (2) @(posedge _w_RDCLK);
        #1;
        _w_GSR = 1'b0;

        reset_state();
        clean_round_trip();
        single_bit_inject();
        double_bit_inject();
        fill_and_overflow();
        read_underflow();
        next_cycle();

        if (fifo_ecc_top_i.fifo_ecc_sva_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Bound assertions failed %0d times",
                     fifo_ecc_top_i.fifo_ecc_sva_i.fail_count);
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+logic
logic/fifo_ecc_pkg.sv
logic/ecc_encoder.sv
logic/fifo_store.sv
logic/ecc_decoder.sv
logic/fifo_ecc_top.sv
verification/fifo_ecc_sva.sv
verification/fifo_ecc_tb.sv

// ==== Bender.yml ====
package:
  name: fifo_ecc

sources:
  - include_dirs:
      - logic
    files:
      - logic/fifo_ecc_pkg.sv
      - logic/ecc_encoder.sv
      - logic/fifo_store.sv
      - logic/ecc_decoder.sv
      - logic/fifo_ecc_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/fifo_ecc_sva.sv
      - verification/fifo_ecc_tb.sv
